//--- hw/rob_pkg.sv
// ----------------------------------------------------------------------
// Shared sizes and types for the reorder buffer
// ROB_DEPTH must stay a power of two so the commit id wraps cleanly
// ----------------------------------------------------------------------

package rob_pkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------
  localparam int DISP_SIZE    = 2;  // Slots per entry
  localparam int ROB_DEPTH    = 8;
  localparam int CMT_BUS_SIZE = 2;  // Done-report ports
  localparam int CMT_ENTRY_W  = 3;
  localparam int CMT_ID_W     = CMT_ENTRY_W + 1;  // Index plus wrap bit
  localparam int FFLAGS_W     = 5;

  // ----------------------------------------------------------------------
  // Types
  // ----------------------------------------------------------------------
  typedef logic [CMT_ID_W-1:0]  cmt_id_t;  // {wrap, index}
  typedef logic [DISP_SIZE-1:0] grp_id_t;  // One-hot slot or entry mask
  typedef logic [FFLAGS_W-1:0]  fflags_t;

  // True when the candidate slot is younger than the reference slot
  // Slot masks are one-hot, so a plain compare gives slot order
  function automatic logic is_younger(input cmt_id_t cand_id,
                                      input grp_id_t cand_grp,
                                      input cmt_id_t ref_id,
                                      input grp_id_t ref_grp);
    logic cand_msb;
    logic ref_msb;
    logic [CMT_ENTRY_W-1:0] cand_idx;
    logic [CMT_ENTRY_W-1:0] ref_idx;
    cand_msb = cand_id[CMT_ID_W-1];
    ref_msb  = ref_id[CMT_ID_W-1];
    cand_idx = cand_id[CMT_ENTRY_W-1:0];
    ref_idx  = ref_id[CMT_ENTRY_W-1:0];
    if (cand_id == ref_id) begin
      return cand_grp > ref_grp;
    end else if (cand_msb == ref_msb) begin
      return cand_idx > ref_idx;
    end else begin
      return cand_idx < ref_idx;  // Reference has not wrapped yet
    end
  endfunction

endpackage

//--- hw/rob_entry.sv
// ----------------------------------------------------------------------
// Done reports match on entry index only and must carry a one-hot slot
// A kill in the load cycle does not reach the entry being loaded
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module rob_entry (
  input  logic                                         i_clk,
  input  logic                                         i_reset_n,
  input  logic [rob_pkg::CMT_ENTRY_W-1:0]              i_entry_idx,
  input  rob_pkg::cmt_id_t                             i_tail_cmt_id,
  input  logic                                         i_load_valid,
  input  rob_pkg::grp_id_t                             i_load_grp_id,
  input  logic [rob_pkg::CMT_BUS_SIZE-1:0]             i_done_valid,
  input  rob_pkg::cmt_id_t [rob_pkg::CMT_BUS_SIZE-1:0] i_done_cmt_id,
  input  rob_pkg::grp_id_t [rob_pkg::CMT_BUS_SIZE-1:0] i_done_grp_id,
  input  logic [rob_pkg::CMT_BUS_SIZE-1:0]             i_done_except,
  input  rob_pkg::fflags_t [rob_pkg::CMT_BUS_SIZE-1:0] i_done_fflags,
  input  logic                                         i_br_update,
  input  rob_pkg::cmt_id_t                             i_br_cmt_id,
  input  rob_pkg::grp_id_t                             i_br_grp_id,
  input  logic                                         i_br_mispredict,
  input  logic                                         i_kill,
  input  logic                                         i_commit_finish,
  output logic                                         o_valid,
  output rob_pkg::cmt_id_t                             o_cmt_id,
  output rob_pkg::grp_id_t                             o_grp_id,
  output rob_pkg::grp_id_t                             o_dead,
  output rob_pkg::grp_id_t                             o_except,
  output rob_pkg::fflags_t [rob_pkg::DISP_SIZE-1:0]    o_fflags,
  output logic                                         o_block_all_done
);
  import rob_pkg::*;

  logic                      r_valid;
  logic                      r_msb;
  grp_id_t                   r_grp_id;
  grp_id_t                   r_done;
  grp_id_t                   r_dead;
  grp_id_t                   r_except;
  fflags_t [DISP_SIZE-1:0]   r_fflags;

  logic                      w_valid_next;
  logic                      w_msb_next;
  grp_id_t                   w_grp_next;
  grp_id_t                   w_done_next;
  grp_id_t                   w_dead_next;
  grp_id_t                   w_except_next;
  fflags_t [DISP_SIZE-1:0]   w_fflags_next;

  cmt_id_t                   w_cmt_id;
  cmt_id_t                   w_load_cmt_id;
  grp_id_t                   w_rpt_valid;
  grp_id_t                   w_rpt_except;
  fflags_t [DISP_SIZE-1:0]   w_rpt_fflags;
  grp_id_t                   w_exc_src;
  grp_id_t                   w_exc_tree;
  grp_id_t                   w_br_kill;
  grp_id_t                   w_br_kill_load;

  assign w_cmt_id      = {r_msb, i_entry_idx};
  assign w_load_cmt_id = {i_tail_cmt_id[CMT_ID_W-1], i_entry_idx};

  // Gather done reports addressed to each slot of this entry
  always_comb begin
    w_rpt_valid  = '0;
    w_rpt_except = '0;
    w_rpt_fflags = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      for (int c = 0; c < CMT_BUS_SIZE; c++) begin
        if (i_done_valid[c] && i_done_cmt_id[c][CMT_ENTRY_W-1:0] == i_entry_idx &&
            i_done_grp_id[c] == grp_id_t'(1 << d)) begin
          w_rpt_valid[d]  = 1'b1;
          w_rpt_except[d] = w_rpt_except[d] | i_done_except[c];
          w_rpt_fflags[d] = w_rpt_fflags[d] | i_done_fflags[c];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Kill sources
  // ----------------------------------------------------------------------
  // Lower-bit tree so every slot after an excepting slot goes dead
  always_comb begin
    w_exc_src     = (w_rpt_valid & w_rpt_except) << 1;
    w_exc_tree[0] = w_exc_src[0];
    for (int d = 1; d < DISP_SIZE; d++) begin
      w_exc_tree[d] = w_exc_tree[d-1] | w_exc_src[d];
    end
  end

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_br_kill[d]      = i_br_update & i_br_mispredict &
                          is_younger(w_cmt_id, grp_id_t'(1 << d), i_br_cmt_id, i_br_grp_id);
      w_br_kill_load[d] = i_br_update & i_br_mispredict &
                          is_younger(w_load_cmt_id, grp_id_t'(1 << d), i_br_cmt_id, i_br_grp_id);
    end
  end

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------
  always_comb begin
    w_valid_next  = r_valid;
    w_msb_next    = r_msb;
    w_grp_next    = r_grp_id;
    w_done_next   = r_done;
    w_dead_next   = r_dead;
    w_except_next = r_except;
    w_fflags_next = r_fflags;

    if (i_load_valid) begin
      w_valid_next  = 1'b1;
      w_msb_next    = i_tail_cmt_id[CMT_ID_W-1];
      w_grp_next    = i_load_grp_id;
      w_done_next   = w_br_kill_load & i_load_grp_id;  // Killed on arrival
      w_dead_next   = w_br_kill_load & i_load_grp_id;
      w_except_next = '0;
      w_fflags_next = '0;
    end

    if (r_valid) begin
      if (i_commit_finish & o_block_all_done) w_valid_next = 1'b0;
      w_done_next   = r_done | w_rpt_valid | (w_br_kill & r_grp_id);
      w_dead_next   = r_dead | ((w_exc_tree | w_br_kill) & r_grp_id);
      w_except_next = r_except | (w_rpt_valid & w_rpt_except);
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (w_rpt_valid[d] && !r_dead[d]) w_fflags_next[d] = w_rpt_fflags[d];
      end
      if (i_kill) w_dead_next = r_grp_id;  // Every grouped slot
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid  <= 1'b0;
      r_msb    <= 1'b0;
      r_grp_id <= '0;
      r_done   <= '0;
      r_dead   <= '0;
      r_except <= '0;
      r_fflags <= '0;
    end else begin
      r_valid  <= w_valid_next;
      r_msb    <= w_msb_next;
      r_grp_id <= w_grp_next;
      r_done   <= w_done_next;
      r_dead   <= w_dead_next;
      r_except <= w_except_next;
      r_fflags <= w_fflags_next;
    end
  end

  assign o_valid          = r_valid;
  assign o_cmt_id         = w_cmt_id;
  assign o_grp_id         = r_grp_id;
  assign o_dead           = r_dead;
  assign o_except         = r_except;
  assign o_fflags         = r_fflags;
  assign o_block_all_done = r_valid & (((r_done | r_dead) & r_grp_id) == r_grp_id);

endmodule

//--- hw/rob_alloc.sv
// ----------------------------------------------------------------------
// Ready depends on registered pointers only
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module rob_alloc (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_disp_valid,
  input  rob_pkg::cmt_id_t              i_head_cmt_id,
  output logic                          o_disp_ready,
  output rob_pkg::cmt_id_t              o_tail_cmt_id,
  output logic [rob_pkg::ROB_DEPTH-1:0] o_load_vec
);
  import rob_pkg::*;

  cmt_id_t                r_tail;
  logic [CMT_ENTRY_W-1:0] w_tail_idx;
  logic [CMT_ENTRY_W-1:0] w_head_idx;
  logic                   w_full;
  logic                   w_accept;

  assign w_tail_idx = r_tail[CMT_ENTRY_W-1:0];
  assign w_head_idx = i_head_cmt_id[CMT_ENTRY_W-1:0];

  // Same index on different laps means every entry is taken
  assign w_full   = (w_tail_idx == w_head_idx) &&
                    (r_tail[CMT_ID_W-1] != i_head_cmt_id[CMT_ID_W-1]);
  assign w_accept = i_disp_valid & ~w_full;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail <= '0;
    end else if (w_accept) begin
      r_tail <= r_tail + 1'b1;  // Wrap bit flips past the last entry
    end
  end

  assign o_disp_ready  = ~w_full;
  assign o_tail_cmt_id = r_tail;
  assign o_load_vec    = w_accept ? (ROB_DEPTH'(1) << w_tail_idx) : '0;

endmodule

//--- hw/rob_commit.sv
// ----------------------------------------------------------------------
// Retires at most one entry per cycle, with no back-pressure on retire
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module rob_commit (
  input  logic                                                          i_clk,
  input  logic                                                          i_reset_n,
  input  logic [rob_pkg::ROB_DEPTH-1:0]                                 i_entry_done,
  input  rob_pkg::grp_id_t [rob_pkg::ROB_DEPTH-1:0]                     i_entry_grp_id,
  input  rob_pkg::grp_id_t [rob_pkg::ROB_DEPTH-1:0]                     i_entry_dead,
  input  rob_pkg::grp_id_t [rob_pkg::ROB_DEPTH-1:0]                     i_entry_except,
  input  rob_pkg::fflags_t [rob_pkg::ROB_DEPTH-1:0][rob_pkg::DISP_SIZE-1:0] i_entry_fflags,
  output rob_pkg::cmt_id_t                                              o_head_cmt_id,
  output logic [rob_pkg::ROB_DEPTH-1:0]                                 o_finish_vec,
  output logic                                                          o_commit_valid,
  output rob_pkg::cmt_id_t                                              o_commit_cmt_id,
  output rob_pkg::grp_id_t                                              o_commit_grp_id,
  output rob_pkg::grp_id_t                                              o_commit_dead,
  output logic                                                          o_commit_except,
  output rob_pkg::fflags_t                                              o_commit_fflags
);
  import rob_pkg::*;

  cmt_id_t                r_head;
  logic [CMT_ENTRY_W-1:0] w_head_idx;
  grp_id_t                w_live;

  assign w_head_idx = r_head[CMT_ENTRY_W-1:0];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
    end else if (o_commit_valid) begin
      r_head <= r_head + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Head entry select
  // ----------------------------------------------------------------------
  assign o_commit_valid  = i_entry_done[w_head_idx];
  assign o_commit_cmt_id = r_head;
  assign o_commit_grp_id = i_entry_grp_id[w_head_idx];
  assign o_commit_dead   = i_entry_dead[w_head_idx];

  assign w_live          = i_entry_grp_id[w_head_idx] & ~i_entry_dead[w_head_idx];
  assign o_commit_except = |(i_entry_except[w_head_idx] & w_live);  // Dead slots never trap

  always_comb begin
    o_commit_fflags = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (w_live[d]) o_commit_fflags = o_commit_fflags | i_entry_fflags[w_head_idx][d];
    end
  end

  assign o_head_cmt_id = r_head;
  assign o_finish_vec  = o_commit_valid ? (ROB_DEPTH'(1) << w_head_idx) : '0;

endmodule

//--- hw/rob_top.sv
// ----------------------------------------------------------------------
// Two-wide reorder buffer with 8 entries and two done-report ports
// Branch and kill strobes act at the edge where they are sampled
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module rob_top (
  input  logic                                         i_clk,
  input  logic                                         i_reset_n,
  input  logic                                         i_disp_valid,
  input  rob_pkg::grp_id_t                             i_disp_grp_id,
  output logic                                         o_disp_ready,
  output rob_pkg::cmt_id_t                             o_disp_cmt_id,
  input  logic [rob_pkg::CMT_BUS_SIZE-1:0]             i_done_valid,
  input  rob_pkg::cmt_id_t [rob_pkg::CMT_BUS_SIZE-1:0] i_done_cmt_id,
  input  rob_pkg::grp_id_t [rob_pkg::CMT_BUS_SIZE-1:0] i_done_grp_id,
  input  logic [rob_pkg::CMT_BUS_SIZE-1:0]             i_done_except,
  input  rob_pkg::fflags_t [rob_pkg::CMT_BUS_SIZE-1:0] i_done_fflags,
  input  logic                                         i_br_update,
  input  rob_pkg::cmt_id_t                             i_br_cmt_id,
  input  rob_pkg::grp_id_t                             i_br_grp_id,
  input  logic                                         i_br_mispredict,
  input  logic                                         i_kill,
  output logic                                         o_commit_valid,
  output rob_pkg::cmt_id_t                             o_commit_cmt_id,
  output rob_pkg::grp_id_t                             o_commit_grp_id,
  output rob_pkg::grp_id_t                             o_commit_dead,
  output logic                                         o_commit_except,
  output rob_pkg::fflags_t                             o_commit_fflags
);
  import rob_pkg::*;

  cmt_id_t                                w_tail_cmt_id;
  cmt_id_t                                w_head_cmt_id;
  logic [ROB_DEPTH-1:0]                   w_load_vec;
  logic [ROB_DEPTH-1:0]                   w_finish_vec;
  logic [ROB_DEPTH-1:0]                   w_entry_valid;
  logic [ROB_DEPTH-1:0]                   w_entry_done;
  grp_id_t [ROB_DEPTH-1:0]                w_entry_grp_id;
  grp_id_t [ROB_DEPTH-1:0]                w_entry_dead;
  grp_id_t [ROB_DEPTH-1:0]                w_entry_except;
  fflags_t [ROB_DEPTH-1:0][DISP_SIZE-1:0] w_entry_fflags;

  assign o_disp_cmt_id = w_tail_cmt_id;  // Id of the group taken at this edge

  for (genvar e = 0; e < ROB_DEPTH; e++) begin : g_entry
    rob_entry u_entry (
      .i_clk            (i_clk),
      .i_reset_n        (i_reset_n),
      .i_entry_idx      (CMT_ENTRY_W'(e)),
      .i_tail_cmt_id    (w_tail_cmt_id),
      .i_load_valid     (w_load_vec[e]),
      .i_load_grp_id    (i_disp_grp_id),
      .i_done_valid     (i_done_valid),
      .i_done_cmt_id    (i_done_cmt_id),
      .i_done_grp_id    (i_done_grp_id),
      .i_done_except    (i_done_except),
      .i_done_fflags    (i_done_fflags),
      .i_br_update      (i_br_update),
      .i_br_cmt_id      (i_br_cmt_id),
      .i_br_grp_id      (i_br_grp_id),
      .i_br_mispredict  (i_br_mispredict),
      .i_kill           (i_kill),
      .i_commit_finish  (w_finish_vec[e]),
      .o_valid          (w_entry_valid[e]),
      .o_cmt_id         (),
      .o_grp_id         (w_entry_grp_id[e]),
      .o_dead           (w_entry_dead[e]),
      .o_except         (w_entry_except[e]),
      .o_fflags         (w_entry_fflags[e]),
      .o_block_all_done (w_entry_done[e])
    );
  end

  rob_alloc u_alloc (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp_valid  (i_disp_valid),
    .i_head_cmt_id (w_head_cmt_id),
    .o_disp_ready  (o_disp_ready),
    .o_tail_cmt_id (w_tail_cmt_id),
    .o_load_vec    (w_load_vec)
  );

  rob_commit u_commit (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_entry_done    (w_entry_done),
    .i_entry_grp_id  (w_entry_grp_id),
    .i_entry_dead    (w_entry_dead),
    .i_entry_except  (w_entry_except),
    .i_entry_fflags  (w_entry_fflags),
    .o_head_cmt_id   (w_head_cmt_id),
    .o_finish_vec    (w_finish_vec),
    .o_commit_valid  (o_commit_valid),
    .o_commit_cmt_id (o_commit_cmt_id),
    .o_commit_grp_id (o_commit_grp_id),
    .o_commit_dead   (o_commit_dead),
    .o_commit_except (o_commit_except),
    .o_commit_fflags (o_commit_fflags)
  );

endmodule

//--- test/rob_assertions.sv
// ----------------------------------------------------------------------
// Bound into every rob_top instance, reads internal pointers and valids
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module rob_assertions (
  input logic                          i_clk,
  input logic                          i_reset_n,
  input logic                          i_commit_valid,
  input rob_pkg::grp_id_t              i_commit_grp_id,
  input logic [rob_pkg::ROB_DEPTH-1:0] i_entry_valid,
  input logic [rob_pkg::ROB_DEPTH-1:0] i_load_vec,
  input rob_pkg::cmt_id_t              i_head_cmt_id,
  input rob_pkg::cmt_id_t              i_tail_cmt_id
);
  import rob_pkg::*;

  // Equal pointers on the same lap leave no allocated head entry
  a_head_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit_valid |-> (i_head_cmt_id != i_tail_cmt_id))
    else $error("commit while head entry is invalid");

  // Loading an occupied entry means a group was taken while full
  a_no_load_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_load_vec & i_entry_valid) == '0)
    else $error("entry loaded while buffer is full");

  a_grp_nonzero: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit_valid |-> (i_commit_grp_id != '0))
    else $error("committed group mask is zero");

endmodule

bind rob_top rob_assertions u_assertions (
  .i_clk           (i_clk),
  .i_reset_n       (i_reset_n),
  .i_commit_valid  (o_commit_valid),
  .i_commit_grp_id (o_commit_grp_id),
  .i_entry_valid   (w_entry_valid),
  .i_load_vec      (w_load_vec),
  .i_head_cmt_id   (w_head_cmt_id),
  .i_tail_cmt_id   (w_tail_cmt_id)
);

//--- test/tb_rob.sv
// ----------------------------------------------------------------------
// Self-checking testbench for rob_top, model tracks entries by sequence
// Kill and branch strobes are only sent while the head is not done
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_rob;
  import rob_pkg::*;

  localparam int MAX_SEQ       = 128;
  localparam int NUM_ENTRIES   = 64;   // Upper bound on dispatched groups
  localparam int CYC_PER_ENTRY = 40;   // Dispatch plus reports, worst case
  localparam int TIMEOUT_CYC   = NUM_ENTRIES * CYC_PER_ENTRY + 100;

  logic                           i_clk;
  logic                           i_reset_n;
  logic                           i_disp_valid;
  grp_id_t                        i_disp_grp_id;
  logic                           o_disp_ready;
  cmt_id_t                        o_disp_cmt_id;
  logic [CMT_BUS_SIZE-1:0]        i_done_valid;
  cmt_id_t [CMT_BUS_SIZE-1:0]     i_done_cmt_id;
  grp_id_t [CMT_BUS_SIZE-1:0]     i_done_grp_id;
  logic [CMT_BUS_SIZE-1:0]        i_done_except;
  fflags_t [CMT_BUS_SIZE-1:0]     i_done_fflags;
  logic                           i_br_update;
  cmt_id_t                        i_br_cmt_id;
  grp_id_t                        i_br_grp_id;
  logic                           i_br_mispredict;
  logic                           i_kill;
  logic                           o_commit_valid;
  cmt_id_t                        o_commit_cmt_id;
  grp_id_t                        o_commit_grp_id;
  grp_id_t                        o_commit_dead;
  logic                           o_commit_except;
  fflags_t                        o_commit_fflags;

  // Reference model state, indexed by dispatch sequence number
  cmt_id_t m_id   [MAX_SEQ];
  grp_id_t m_grp  [MAX_SEQ];
  grp_id_t m_done [MAX_SEQ];
  grp_id_t m_dead [MAX_SEQ];
  grp_id_t m_exc  [MAX_SEQ];
  fflags_t m_ff   [MAX_SEQ][DISP_SIZE];
  int      pend_q[$];           // Dispatched, not yet retired
  int      n_seq  = 0;
  cmt_id_t exp_id = '0;
  int      seed   = 32'hc964e00c;
  int      cycles = 0;

  rob_top UUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles > TIMEOUT_CYC) begin
      $display("Timeout: entries did not retire within %0d cycles", TIMEOUT_CYC);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // {dead mask, exception, fflags} from the model entry
  function automatic logic [7:0] expected_commit(input int s);
    grp_id_t live;
    logic    exc;
    fflags_t ff;
    live = m_grp[s] & ~m_dead[s];
    exc  = |(m_exc[s] & live);
    ff   = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (live[d]) ff = ff | m_ff[s][d];
    end
    return {m_dead[s], exc, ff};
  endfunction

  // Compare every retire pulse with the oldest model entry
  always @(negedge i_clk) begin
    int s;
    logic [7:0] exp;
    if (i_reset_n && o_commit_valid) begin
      if (pend_q.size() == 0) begin
        $display("Commit seen with no dispatched entry outstanding");
        $display("TESTBENCH FAILED");
        $fatal(1);
      end
      s = pend_q.pop_front();
      if (((m_done[s] | m_dead[s]) & m_grp[s]) != m_grp[s]) begin
        $display("Entry %0d retired before all of its slots finished", s);
        $display("TESTBENCH FAILED");
        $fatal(1);
      end
      exp = expected_commit(s);
      check_val("o_commit_cmt_id", o_commit_cmt_id, m_id[s]);
      check_val("o_commit_grp_id", o_commit_grp_id, m_grp[s]);
      check_val("o_commit_dead", o_commit_dead, exp[7:6]);
      check_val("o_commit_except", o_commit_except, exp[5]);
      check_val("o_commit_fflags", o_commit_fflags, exp[4:0]);
    end
  end

  // Model update for one done report
  function automatic void apply_done(input int s, input int slot, input logic e,
                                     input fflags_t f);
    if (!m_dead[s][slot]) m_ff[s][slot] = f;
    m_done[s][slot] = 1'b1;
    m_exc[s][slot]  = m_exc[s][slot] | e;
    if (e) begin
      for (int d = slot + 1; d < DISP_SIZE; d++) m_dead[s][d] = m_dead[s][d] | m_grp[s][d];
    end
  endfunction

  task automatic dispatch(input grp_id_t g);
    @(posedge i_clk);
    i_disp_valid  <= 1'b1;
    i_disp_grp_id <= g;
    do @(posedge i_clk); while (!o_disp_ready);
    check_val("o_disp_cmt_id", o_disp_cmt_id, exp_id);
    m_id[n_seq]   = exp_id;
    m_grp[n_seq]  = g;
    m_done[n_seq] = '0;
    m_dead[n_seq] = '0;
    m_exc[n_seq]  = '0;
    for (int d = 0; d < DISP_SIZE; d++) m_ff[n_seq][d] = '0;
    pend_q.push_back(n_seq);
    n_seq++;
    exp_id = exp_id + 1'b1;
    i_disp_valid <= 1'b0;
  endtask

  function automatic grp_id_t rand_grp();
    case ($unsigned($random(seed)) % 3)
      0:       return 2'b01;
      1:       return 2'b10;
      default: return 2'b11;
    endcase
  endfunction

  // One cycle of reports on up to two ports
  task automatic drive_done(input logic [1:0] vmask, input int sa, input int la,
                            input logic ea, input fflags_t fa, input int sb,
                            input int lb, input logic eb, input fflags_t fb);
    @(posedge i_clk);
    i_done_valid     <= vmask;
    i_done_cmt_id[0] <= m_id[sa];
    i_done_grp_id[0] <= grp_id_t'(1 << la);
    i_done_except[0] <= ea;
    i_done_fflags[0] <= fa;
    i_done_cmt_id[1] <= m_id[sb];
    i_done_grp_id[1] <= grp_id_t'(1 << lb);
    i_done_except[1] <= eb;
    i_done_fflags[1] <= fb;
    if (vmask[0]) apply_done(sa, la, ea, fa);
    if (vmask[1]) apply_done(sb, lb, eb, fb);
    @(posedge i_clk);
    i_done_valid <= '0;
  endtask

  // Report every open slot of the outstanding entries in shuffled order
  task automatic report_all_pending();
    int      rs[$];
    int      rl[$];
    int      j;
    int      t;
    logic    e[2];
    fflags_t f[2];
    foreach (pend_q[i]) begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (m_grp[pend_q[i]][d] && !m_done[pend_q[i]][d] && !m_dead[pend_q[i]][d]) begin
          rs.push_back(pend_q[i]);
          rl.push_back(d);
        end
      end
    end
    for (int i = rs.size() - 1; i > 0; i--) begin
      j = $unsigned($random(seed)) % (i + 1);
      t = rs[i];
      rs[i] = rs[j];
      rs[j] = t;
      t = rl[i];
      rl[i] = rl[j];
      rl[j] = t;
    end
    while (rs.size() > 0) begin
      for (int k = 0; k < 2; k++) begin
        e[k] = (($random(seed) & 7) == 0);  // Rare exception
        f[k] = fflags_t'($random(seed));
      end
      if (rs.size() >= 2) begin
        drive_done(2'b11, rs[0], rl[0], e[0], f[0], rs[1], rl[1], e[1], f[1]);
        rs.pop_front();
        rl.pop_front();
      end else begin
        drive_done(2'b01, rs[0], rl[0], e[0], f[0], 0, 0, 1'b0, '0);
      end
      rs.pop_front();
      rl.pop_front();
    end
  endtask

  task automatic wait_drain();
    while (pend_q.size() > 0) @(posedge i_clk);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    int bpos;
    int exc_seq;
    int or_seq;
    int head_seq;
    i_reset_n       <= 1'b0;
    i_disp_valid    <= 1'b0;
    i_disp_grp_id   <= '0;
    i_done_valid    <= '0;
    i_done_cmt_id   <= '0;
    i_done_grp_id   <= '0;
    i_done_except   <= '0;
    i_done_fflags   <= '0;
    i_br_update     <= 1'b0;
    i_br_cmt_id     <= '0;
    i_br_grp_id     <= '0;
    i_br_mispredict <= 1'b0;
    i_kill          <= 1'b0;
    repeat (10) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(negedge i_clk);
    check_val("o_disp_ready", o_disp_ready, 1'b1);
    check_val("o_commit_valid", o_commit_valid, 1'b0);

    // Random batches, reports out of order
    for (int b = 0; b < 4; b++) begin
      for (int i = 0; i < 6; i++) dispatch(rand_grp());
      report_all_pending();
      wait_drain();
    end

    // Exception in slot 0 drops slot 1 and its flags, then a plain flag OR
    dispatch(2'b11);
    dispatch(2'b11);
    exc_seq = pend_q[0];
    or_seq  = pend_q[1];
    drive_done(2'b11, exc_seq, 0, 1'b1, 5'h03, exc_seq, 1, 1'b0, 5'h10);
    drive_done(2'b11, or_seq, 1, 1'b0, 5'h04, or_seq, 0, 1'b0, 5'h01);
    wait_drain();

    // Mispredict in slot 0 of the second entry
    dispatch(rand_grp());
    dispatch(2'b11);
    dispatch(rand_grp());
    dispatch(rand_grp());
    bpos = 1;
    @(posedge i_clk);
    i_br_update     <= 1'b1;
    i_br_mispredict <= 1'b1;
    i_br_cmt_id     <= m_id[pend_q[bpos]];
    i_br_grp_id     <= 2'b01;
    m_dead[pend_q[bpos]] = m_dead[pend_q[bpos]] | (m_grp[pend_q[bpos]] & 2'b10);
    m_done[pend_q[bpos]] = m_done[pend_q[bpos]] | (m_grp[pend_q[bpos]] & 2'b10);
    for (int i = bpos + 1; i < pend_q.size(); i++) begin
      m_dead[pend_q[i]] = m_grp[pend_q[i]];
      m_done[pend_q[i]] = m_grp[pend_q[i]];
    end
    @(posedge i_clk);
    i_br_update     <= 1'b0;
    i_br_mispredict <= 1'b0;
    repeat (3) @(posedge i_clk);
    check_val("pending entries", pend_q.size(), 4);
    report_all_pending();
    wait_drain();

    // External kill with no reports at all
    for (int i = 0; i < 3; i++) dispatch(rand_grp());
    @(posedge i_clk);
    i_kill <= 1'b1;
    foreach (pend_q[i]) m_dead[pend_q[i]] = m_grp[pend_q[i]];
    @(posedge i_clk);
    i_kill <= 1'b0;
    wait_drain();

    // Fill all entries, then hold a dispatch until the head retires
    for (int i = 0; i < ROB_DEPTH; i++) dispatch(rand_grp());
    @(negedge i_clk);
    check_val("o_disp_ready", o_disp_ready, 1'b0);
    head_seq = pend_q[0];
    fork
      dispatch(rand_grp());
      begin
        for (int d = 0; d < DISP_SIZE; d++) begin
          if (m_grp[head_seq][d]) begin
            drive_done(2'b01, head_seq, d, 1'b0, 5'h08, 0, 0, 1'b0, '0);
          end
        end
      end
    join
    report_all_pending();
    wait_drain();

    repeat (4) @(posedge i_clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- sources.f
hw/rob_pkg.sv
hw/rob_entry.sv
hw/rob_alloc.sv
hw/rob_commit.sv
hw/rob_top.sv
test/rob_assertions.sv
test/tb_rob.sv
